// ==== hw/shifter_fetch.sv ====
// video memory fetch engine, one word per 16 slot bus cycle, 16 pixels ahead of display
module shifter_fetch #(
	parameter shifter_pkg::hcnt_t H_END          = shifter_pkg::DEF_H_END,
	parameter shifter_pkg::hcnt_t H_BORDER_RIGHT = shifter_pkg::DEF_H_BORDER_RIGHT,
	parameter shifter_pkg::hcnt_t H_BORDER_LEFT  = shifter_pkg::DEF_H_BORDER_LEFT,
	parameter shifter_pkg::hcnt_t V_END          = shifter_pkg::DEF_V_END,
	parameter shifter_pkg::hcnt_t V_BORDER_BOT   = shifter_pkg::DEF_V_BORDER_BOT,
	parameter shifter_pkg::hcnt_t V_SYNC         = shifter_pkg::DEF_V_SYNC
) (
	input  logic               clk,
	input  logic               reg_reset,
	input  logic [3:0]         bus_cycle,
	input  shifter_pkg::hcnt_t hcnt,
	input  shifter_pkg::hcnt_t vcnt,
	input  shifter_pkg::addr_t base_addr,
	input  shifter_pkg::word_t data,
	output logic               read,
	output shifter_pkg::addr_t vaddr,
	output shifter_pkg::word_t word,
	output logic               st_de
);
	import shifter_pkg::*;

	// horizontal fetch window, one word of prefetch ahead of display
	localparam hcnt_t ME_H_START  = hcnt_t'(H_END - PIXELS_PER_WORD);
	localparam hcnt_t ME_H_STOP   = hcnt_t'(H_BORDER_RIGHT - PIXELS_PER_WORD);
	// counter reload a few lines before vsync
	localparam hcnt_t RELOAD_LINE = hcnt_t'(V_SYNC - 3);

	// memory enable, horizontal and vertical
	logic  me;
	logic  me_v;
	// previous vcnt, used to spot the line advance
	hcnt_t vcnt_q;
	logic  line_tick;
	logic  reload;
	logic  fetch;

	assign line_tick = (vcnt != vcnt_q);
	assign reload    = (hcnt == H_BORDER_LEFT) && (vcnt == RELOAD_LINE);
	assign fetch     = me && (bus_cycle == FETCH_SLOT);

	// slots 0..3 belong to video, me is the read request as is
	assign read  = me && (bus_cycle[3:2] == 2'b00);
	// active low display enable for the mfp timer
	assign st_de = ~me;

	always_ff @(posedge clk) begin
		if (reg_reset) begin
			me     <= 1'b0;
			me_v   <= 1'b0;
			vcnt_q <= '0;
			vaddr  <= '0;
		end else begin
			vcnt_q <= vcnt;
			// vertical window opens when the frame wraps and closes after
			// the last display line
			if (line_tick) begin
				if (vcnt_q == V_END) begin
					me_v <= 1'b1;
				end
				if (vcnt_q == V_BORDER_BOT) begin
					me_v <= 1'b0;
				end
			end

			// odd slot only, so enable never splits a 4 slot access
			if (me_v && bus_cycle[0]) begin
				if (hcnt == ME_H_START) begin
					me <= 1'b1;
				end
				if (hcnt == ME_H_STOP) begin
					me <= 1'b0;
				end
			end

			if (reload) begin
				vaddr <= base_addr;
			end else if (fetch) begin
				vaddr <= vaddr + 23'd1;
			end
		end
	end

	// data is valid in the fetch slot
	always_ff @(posedge clk) begin
		if (fetch) begin
			word <= data;
		end
	end

	a_vaddr_step: assert property (@(posedge clk) disable iff (reg_reset)
		$changed(vaddr) |-> $past((bus_cycle == FETCH_SLOT) || reload))
		else $error("vaddr moved outside fetch slot and reload");

endmodule

// ==== hw/shifter_pixel.sv ====
// mono pixel stage, shifts the fetched word out and drives blanked rgb and registered sync
module shifter_pixel #(
	parameter logic H_SYNC_POL = 1'b0,
	parameter logic V_SYNC_POL = 1'b0
) (
	input  logic                 clk,
	input  logic                 reg_reset,
	input  shifter_pkg::hcnt_t   hcnt,
	input  shifter_pkg::vstate_t h_state,
	input  shifter_pkg::vstate_t v_state,
	input  logic                 h_sync_raw,
	input  logic                 v_sync_raw,
	input  shifter_pkg::word_t   word,
	input  logic                 invert,
	output logic                 hs,
	output logic                 vs,
	output logic [5:0]           video_r,
	output logic [5:0]           video_g,
	output logic [5:0]           video_b
);
	import shifter_pkg::*;

	word_t      shift_q;
	logic       de;
	logic       blank;
	logic       pix;
	logic [5:0] level;

	// reload on the last pixel of each word, else one pixel per clock
	always_ff @(posedge clk) begin
		if (hcnt[3:0] == 4'(PIXELS_PER_WORD - 1)) begin
			shift_q <= word;
		end else begin
			shift_q <= {shift_q[14:0], 1'b0};
		end
	end

	// blank also covers the sync phases
	assign blank = (h_state == ST_SYNC) || (h_state == ST_BLANK) ||
		(v_state == ST_SYNC) || (v_state == ST_BLANK);
	assign de    = (h_state == ST_DISPLAY) && (v_state == ST_DISPLAY);
	assign pix   = shift_q[15] ^ invert;
	// border is a fixed mid grey
	assign level = de ? {6{pix}} : 6'b100100;

	always_ff @(posedge clk) begin
		if (reg_reset) begin
			hs      <= ~H_SYNC_POL;
			vs      <= ~V_SYNC_POL;
			video_r <= '0;
			video_g <= '0;
			video_b <= '0;
		end else begin
			hs      <= h_sync_raw ? H_SYNC_POL : ~H_SYNC_POL;
			vs      <= v_sync_raw ? V_SYNC_POL : ~V_SYNC_POL;
			video_r <= blank ? 6'b000000 : level;
			video_g <= blank ? 6'b000000 : level;
			video_b <= blank ? 6'b000000 : level;
		end
	end

endmodule

// ==== hw/shifter_pkg.sv ====
// shared types, register map, state encodings and default 640x400 mono timing for the shifter
package shifter_pkg;

	// ------------------------------------------------------------------------
	// basic types
	// ------------------------------------------------------------------------

	// video word address, 16 bit words
	typedef logic [22:0] addr_t;
	// cpu bus and memory data
	typedef logic [15:0] word_t;
	// cpu register index
	typedef logic [5:0]  reg_addr_t;
	// horizontal and vertical counters share one width
	typedef logic [9:0]  hcnt_t;

	// timing phase, same encoding for both axes
	typedef enum logic [1:0] {
		ST_SYNC    = 2'd0,
		ST_BLANK   = 2'd1,
		ST_BORDER  = 2'd2,
		ST_DISPLAY = 2'd3
	} vstate_t;

	// ------------------------------------------------------------------------
	// register map
	// ------------------------------------------------------------------------
	localparam reg_addr_t REG_BASE_HI  = 6'h00;
	localparam reg_addr_t REG_BASE_LO  = 6'h01;
	localparam reg_addr_t REG_ADDR_HI  = 6'h02;
	localparam reg_addr_t REG_ADDR_MID = 6'h03;
	localparam reg_addr_t REG_ADDR_LO  = 6'h04;
	localparam reg_addr_t REG_SYNCMODE = 6'h05;
	localparam reg_addr_t REG_PALETTE0 = 6'h20;
	localparam reg_addr_t REG_SHMODE   = 6'h30;

	// base address after reset, word address 0x8000 is byte 0x10000
	localparam addr_t      BASE_ADDR_RESET = 23'h8000;
	localparam logic [1:0] SHMODE_MONO     = 2'd2;

	// bus slot schedule
	localparam logic [3:0] FETCH_SLOT = 4'd3;
	localparam logic [3:0] LINE_SLOT  = 4'd15;

	localparam int PIXELS_PER_WORD = 16;

	// ------------------------------------------------------------------------
	// default mono timing, each value is the last count of the phase before it
	// ------------------------------------------------------------------------
	localparam hcnt_t DEF_H_BORDER_RIGHT = 10'd639;
	localparam hcnt_t DEF_H_BLANK_RIGHT  = 10'd663;
	localparam hcnt_t DEF_H_SYNC         = 10'd703;
	localparam hcnt_t DEF_H_BLANK_LEFT   = 10'd799;
	localparam hcnt_t DEF_H_BORDER_LEFT  = 10'd871;
	// 896 clocks per line, a multiple of the 16 slot bus cycle
	localparam hcnt_t DEF_H_END          = 10'd895;

	localparam hcnt_t DEF_V_BORDER_BOT   = 10'd399;
	localparam hcnt_t DEF_V_BLANK_BOT    = 10'd409;
	localparam hcnt_t DEF_V_SYNC         = 10'd419;
	localparam hcnt_t DEF_V_BLANK_TOP    = 10'd421;
	localparam hcnt_t DEF_V_BORDER_TOP   = 10'd451;
	localparam hcnt_t DEF_V_END          = 10'd500;

endpackage

// ==== hw/shifter_regs.sv ====
// cpu visible shifter registers, byte lane writes on clk and a combinational read mux
module shifter_regs (
	input  logic                   clk,
	input  logic                   reg_reset,
	input  logic                   reg_sel,
	input  logic                   reg_rw,
	input  logic                   reg_uds,
	input  logic                   reg_lds,
	input  shifter_pkg::reg_addr_t reg_addr,
	input  shifter_pkg::word_t     reg_din,
	output shifter_pkg::word_t     reg_dout,
	input  shifter_pkg::addr_t     vaddr,
	output shifter_pkg::addr_t     base_addr,
	output logic [1:0]             shmode,
	output logic [1:0]             syncmode,
	output logic                   invert
);
	import shifter_pkg::*;

	// base address bits 22:7, the low seven bits are always zero
	logic [15:0] base_q;
	// palette entry 0, three bits per gun
	logic [2:0]  pal_r;
	logic [2:0]  pal_g;
	logic [2:0]  pal_b;
	logic        wr;

	assign wr = reg_sel && !reg_rw;

	// ------------------------------------------------------------------------
	// register write
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reg_reset) begin
			base_q   <= BASE_ADDR_RESET[22:7];
			shmode   <= SHMODE_MONO;
			// 60 Hz
			syncmode <= 2'b00;
			pal_r    <= 3'b000;
			pal_g    <= 3'b000;
			// mono tos expects blue set, i.e. inverted video
			pal_b    <= 3'b111;
		end else if (wr) begin
			case (reg_addr)
				// base bytes live on the low lane
				REG_BASE_HI: begin
					if (!reg_lds) begin
						base_q[15:8] <= reg_din[7:0];
					end
				end
				REG_BASE_LO: begin
					if (!reg_lds) begin
						base_q[7:0] <= reg_din[7:0];
					end
				end
				// mode registers sit on the high lane
				REG_SYNCMODE: begin
					if (!reg_uds) begin
						syncmode <= reg_din[9:8];
					end
				end
				REG_SHMODE: begin
					if (!reg_uds) begin
						shmode <= reg_din[9:8];
					end
				end
				// red on the upper byte, green and blue on the lower one
				REG_PALETTE0: begin
					if (!reg_uds) begin
						pal_r <= reg_din[10:8];
					end
					if (!reg_lds) begin
						pal_g <= reg_din[6:4];
						pal_b <= reg_din[2:0];
					end
				end
				default: ;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// register read, zero unless a read is selected
	// ------------------------------------------------------------------------
	always_comb begin
		reg_dout = '0;
		if (reg_sel && reg_rw) begin
			case (reg_addr)
				REG_BASE_HI:  reg_dout = {8'h00, base_q[15:8]};
				REG_BASE_LO:  reg_dout = {8'h00, base_q[7:0]};
				// live address counter, byte address so bit 0 reads zero
				REG_ADDR_HI:  reg_dout = {8'h00, vaddr[22:15]};
				REG_ADDR_MID: reg_dout = {8'h00, vaddr[14:7]};
				REG_ADDR_LO:  reg_dout = {8'h00, vaddr[6:0], 1'b0};
				REG_SYNCMODE: reg_dout = {6'h00, syncmode, 8'h00};
				REG_PALETTE0: reg_dout = {5'h00, pal_r, 1'b0, pal_g, 1'b0, pal_b};
				REG_SHMODE:   reg_dout = {6'h00, shmode, 8'h00};
				default:      reg_dout = '0;
			endcase
		end
	end

	assign base_addr = {base_q, 7'b0000000};
	// mono inversion comes from the blue lsb only
	assign invert = pal_b[0];

	// cpu must not write while the shifter is held in reset
	a_no_write_in_reset: assert property (@(posedge clk) reg_reset |-> !wr)
		else $error("register write during reset");

endmodule

// ==== hw/shifter_timing.sv ====
// horizontal and vertical timing generator, locks the line to the bus cycle and decodes phases
module shifter_timing #(
	parameter shifter_pkg::hcnt_t H_BORDER_RIGHT = shifter_pkg::DEF_H_BORDER_RIGHT,
	parameter shifter_pkg::hcnt_t H_BLANK_RIGHT  = shifter_pkg::DEF_H_BLANK_RIGHT,
	parameter shifter_pkg::hcnt_t H_SYNC         = shifter_pkg::DEF_H_SYNC,
	parameter shifter_pkg::hcnt_t H_BLANK_LEFT   = shifter_pkg::DEF_H_BLANK_LEFT,
	parameter shifter_pkg::hcnt_t H_BORDER_LEFT  = shifter_pkg::DEF_H_BORDER_LEFT,
	parameter shifter_pkg::hcnt_t H_END          = shifter_pkg::DEF_H_END,
	parameter shifter_pkg::hcnt_t V_BORDER_BOT   = shifter_pkg::DEF_V_BORDER_BOT,
	parameter shifter_pkg::hcnt_t V_BLANK_BOT    = shifter_pkg::DEF_V_BLANK_BOT,
	parameter shifter_pkg::hcnt_t V_SYNC         = shifter_pkg::DEF_V_SYNC,
	parameter shifter_pkg::hcnt_t V_BLANK_TOP    = shifter_pkg::DEF_V_BLANK_TOP,
	parameter shifter_pkg::hcnt_t V_BORDER_TOP   = shifter_pkg::DEF_V_BORDER_TOP,
	parameter shifter_pkg::hcnt_t V_END          = shifter_pkg::DEF_V_END
) (
	input  logic                 clk,
	input  logic                 reg_reset,
	input  logic [3:0]           bus_cycle,
	output shifter_pkg::hcnt_t   hcnt,
	output shifter_pkg::hcnt_t   vcnt,
	output shifter_pkg::vstate_t h_state,
	output shifter_pkg::vstate_t v_state,
	output logic                 h_sync_raw,
	output logic                 v_sync_raw
);
	import shifter_pkg::*;

	// vertical events happen once per line, at the start of hsync
	logic line_tick;

	assign line_tick = (hcnt == H_SYNC);

	// ------------------------------------------------------------------------
	// horizontal counter
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reg_reset) begin
			hcnt <= '0;
		end else if (hcnt == H_END) begin
			// wait at the line end until the bus cycle wraps too,
			// this keeps hcnt[3:0] equal to bus_cycle
			if (bus_cycle == LINE_SLOT) begin
				hcnt <= '0;
			end
		end else begin
			hcnt <= hcnt + 10'd1;
		end
	end

	// ------------------------------------------------------------------------
	// horizontal phase and raw hsync
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reg_reset) begin
			h_state    <= ST_BLANK;
			h_sync_raw <= 1'b0;
		end else begin
			if (hcnt == H_SYNC) begin
				h_state    <= ST_SYNC;
				h_sync_raw <= 1'b1;
			end
			if ((hcnt == H_BORDER_RIGHT) || (hcnt == H_BORDER_LEFT)) begin
				h_state <= ST_BORDER;
			end
			if ((hcnt == H_BLANK_RIGHT) || (hcnt == H_BLANK_LEFT)) begin
				h_state <= ST_BLANK;
			end
			// sync ends where the left blank begins
			if (hcnt == H_BLANK_LEFT) begin
				h_sync_raw <= 1'b0;
			end
			if (hcnt == H_END) begin
				h_state <= ST_DISPLAY;
			end
		end
	end

	// ------------------------------------------------------------------------
	// vertical counter, phase and raw vsync
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reg_reset) begin
			vcnt       <= '0;
			v_state    <= ST_BLANK;
			v_sync_raw <= 1'b0;
		end else if (line_tick) begin
			if (vcnt == V_END) begin
				vcnt <= '0;
			end else begin
				vcnt <= vcnt + 10'd1;
			end

			if (vcnt == V_SYNC) begin
				v_state    <= ST_SYNC;
				v_sync_raw <= 1'b1;
			end
			if ((vcnt == V_BORDER_BOT) || (vcnt == V_BORDER_TOP)) begin
				v_state <= ST_BORDER;
			end
			if ((vcnt == V_BLANK_BOT) || (vcnt == V_BLANK_TOP)) begin
				v_state <= ST_BLANK;
			end
			if (vcnt == V_BLANK_TOP) begin
				v_sync_raw <= 1'b0;
			end
			// first display line follows the frame wrap
			if (vcnt == V_END) begin
				v_state <= ST_DISPLAY;
			end
		end
	end

	// line wrap waits for the bus slot but never runs past the line end
	a_hcnt_range: assert property (@(posedge clk) disable iff (reg_reset) hcnt <= H_END)
		else $error("hcnt beyond line end");

endmodule

// ==== hw/shifter_top.sv ====
// top of the mono shifter, wires register file, timing, fetch and pixel stage together
module shifter_top #(
	parameter shifter_pkg::hcnt_t H_BORDER_RIGHT = shifter_pkg::DEF_H_BORDER_RIGHT,
	parameter shifter_pkg::hcnt_t H_BLANK_RIGHT  = shifter_pkg::DEF_H_BLANK_RIGHT,
	parameter shifter_pkg::hcnt_t H_SYNC         = shifter_pkg::DEF_H_SYNC,
	parameter shifter_pkg::hcnt_t H_BLANK_LEFT   = shifter_pkg::DEF_H_BLANK_LEFT,
	parameter shifter_pkg::hcnt_t H_BORDER_LEFT  = shifter_pkg::DEF_H_BORDER_LEFT,
	parameter shifter_pkg::hcnt_t H_END          = shifter_pkg::DEF_H_END,
	parameter shifter_pkg::hcnt_t V_BORDER_BOT   = shifter_pkg::DEF_V_BORDER_BOT,
	parameter shifter_pkg::hcnt_t V_BLANK_BOT    = shifter_pkg::DEF_V_BLANK_BOT,
	parameter shifter_pkg::hcnt_t V_SYNC         = shifter_pkg::DEF_V_SYNC,
	parameter shifter_pkg::hcnt_t V_BLANK_TOP    = shifter_pkg::DEF_V_BLANK_TOP,
	parameter shifter_pkg::hcnt_t V_BORDER_TOP   = shifter_pkg::DEF_V_BORDER_TOP,
	parameter shifter_pkg::hcnt_t V_END          = shifter_pkg::DEF_V_END,
	// mono monitor sync, active low
	parameter logic               H_SYNC_POL     = 1'b0,
	parameter logic               V_SYNC_POL     = 1'b0
) (
	input  logic                   clk,
	input  logic                   reg_reset,
	input  logic [3:0]             bus_cycle,
	// cpu register bus
	input  logic                   reg_sel,
	input  logic                   reg_rw,
	input  logic                   reg_uds,
	input  logic                   reg_lds,
	input  shifter_pkg::reg_addr_t reg_addr,
	input  shifter_pkg::word_t     reg_din,
	output shifter_pkg::word_t     reg_dout,
	// video memory port
	output logic                   read,
	output shifter_pkg::addr_t     vaddr,
	input  shifter_pkg::word_t     data,
	// monitor side
	output logic                   hs,
	output logic                   vs,
	output logic [5:0]             video_r,
	output logic [5:0]             video_g,
	output logic [5:0]             video_b,
	// raw st signals for the interrupt logic
	output logic                   st_de,
	output logic                   st_hs,
	output logic                   st_vs
);
	import shifter_pkg::*;

	addr_t   base_addr;
	logic    invert;
	hcnt_t   hcnt;
	hcnt_t   vcnt;
	vstate_t h_state;
	vstate_t v_state;
	logic    h_sync_raw;
	logic    v_sync_raw;
	word_t   word;

	// mode registers are readback only in the mono path
	shifter_regs u_regs (
		.clk(clk), .reg_reset(reg_reset), .reg_sel(reg_sel), .reg_rw(reg_rw),
		.reg_uds(reg_uds), .reg_lds(reg_lds), .reg_addr(reg_addr), .reg_din(reg_din),
		.reg_dout(reg_dout), .vaddr(vaddr), .base_addr(base_addr), .shmode(),
		.syncmode(), .invert(invert)
	);

	shifter_timing #(
		.H_BORDER_RIGHT(H_BORDER_RIGHT), .H_BLANK_RIGHT(H_BLANK_RIGHT), .H_SYNC(H_SYNC),
		.H_BLANK_LEFT(H_BLANK_LEFT), .H_BORDER_LEFT(H_BORDER_LEFT), .H_END(H_END),
		.V_BORDER_BOT(V_BORDER_BOT), .V_BLANK_BOT(V_BLANK_BOT), .V_SYNC(V_SYNC),
		.V_BLANK_TOP(V_BLANK_TOP), .V_BORDER_TOP(V_BORDER_TOP), .V_END(V_END)
	) u_timing (
		.clk(clk), .reg_reset(reg_reset), .bus_cycle(bus_cycle), .hcnt(hcnt),
		.vcnt(vcnt), .h_state(h_state), .v_state(v_state), .h_sync_raw(h_sync_raw),
		.v_sync_raw(v_sync_raw)
	);

	shifter_fetch #(
		.H_END(H_END), .H_BORDER_RIGHT(H_BORDER_RIGHT), .H_BORDER_LEFT(H_BORDER_LEFT),
		.V_END(V_END), .V_BORDER_BOT(V_BORDER_BOT), .V_SYNC(V_SYNC)
	) u_fetch (
		.clk(clk), .reg_reset(reg_reset), .bus_cycle(bus_cycle), .hcnt(hcnt),
		.vcnt(vcnt), .base_addr(base_addr), .data(data), .read(read), .vaddr(vaddr),
		.word(word), .st_de(st_de)
	);

	shifter_pixel #(
		.H_SYNC_POL(H_SYNC_POL), .V_SYNC_POL(V_SYNC_POL)
	) u_pixel (
		.clk(clk), .reg_reset(reg_reset), .hcnt(hcnt), .h_state(h_state),
		.v_state(v_state), .h_sync_raw(h_sync_raw), .v_sync_raw(v_sync_raw),
		.word(word), .invert(invert), .hs(hs), .vs(vs), .video_r(video_r),
		.video_g(video_g), .video_b(video_b)
	);

	// irq side sees the unregistered pulses
	assign st_hs = h_sync_raw;
	assign st_vs = v_sync_raw;

endmodule

// ==== shifter.f ====
hw/shifter_pkg.sv
hw/shifter_regs.sv
hw/shifter_timing.sv
hw/shifter_fetch.sv
hw/shifter_pixel.sv
hw/shifter_top.sv
testbench/tb_shifter.sv

// ==== testbench/shifter_patterns.txt ====
// register records: index, strobes {uds, lds} active low, write data, readback
// @40 holds the video memory image, one word per address from the base upward
@00
0000 0 0012 0012 // base high byte
0001 0 0034 0034 // base low byte
0000 1 00ff 0012 // upper strobe only, base high keeps its value
0005 0 0200 0200 // sync mode 50 Hz
0005 2 0100 0200 // lower strobe only, sync mode unchanged
0030 2 0100 0200 // shift mode keeps mono
0020 0 fdef 0567 // palette 0, fields packed
0020 1 0200 0267 // red only
0020 2 0031 0231 // green and blue only
0001 2 ab80 0080 // base low, upper byte ignored
ffff 0 0000 0000
@40
ffff 0000 8001 7ffe 1234 5678 9abc def0
0f0f f0f0 aaaa 5555 0001 8000 c3c3 3c3c
1111 2222 4444 8888 fedc ba98 7654 3210
00ff ff00 0ff0 f00f 6996 9669 a5a5 5a5a
cafe babe 0bad f00d 1357 2468 ace0 bdf1
7777 eeee 0003 c000 3333 cccc 0707 7070

// ==== testbench/tb_shifter.sv ====
// self-checking testbench for the mono shifter, compile with the file list, top is tb_shifter
module tb_shifter;
	import shifter_pkg::*;

	// ------------------------------------------------------------------------
	// reduced frame, 64x12 display inside 16 pixel borders
	// ------------------------------------------------------------------------
	localparam hcnt_t T_H_BORDER_RIGHT = 10'd63;
	localparam hcnt_t T_H_BLANK_RIGHT  = 10'd79;
	localparam hcnt_t T_H_SYNC         = 10'd87;
	localparam hcnt_t T_H_BLANK_LEFT   = 10'd95;
	localparam hcnt_t T_H_BORDER_LEFT  = 10'd111;
	localparam hcnt_t T_H_END          = 10'd127;
	localparam hcnt_t T_V_BORDER_BOT   = 10'd11;
	localparam hcnt_t T_V_BLANK_BOT    = 10'd13;
	localparam hcnt_t T_V_SYNC         = 10'd15;
	localparam hcnt_t T_V_BLANK_TOP    = 10'd17;
	localparam hcnt_t T_V_BORDER_TOP   = 10'd19;
	localparam hcnt_t T_V_END          = 10'd21;
	// active low sync on both axes
	localparam logic  H_POL = 1'b0;
	localparam logic  V_POL = 1'b0;

	localparam int FRAME_CLKS      = (T_H_END + 1) * (T_V_END + 1);
	localparam int WORDS_PER_LINE  = (T_H_BORDER_RIGHT + 1) / PIXELS_PER_WORD;
	localparam int WORDS_PER_FRAME = (T_V_BORDER_BOT + 1) * WORDS_PER_LINE;
	// fetch window is the display width moved one word earlier
	localparam int DE_CLKS         = (T_V_BORDER_BOT + 1) * (T_H_BORDER_RIGHT + 1);
	localparam int HS_CLKS         = (T_V_END + 1) * (T_H_BLANK_LEFT - T_H_SYNC);
	localparam int VS_CLKS         = (T_V_BLANK_TOP - T_V_SYNC) * (T_H_END + 1);
	localparam int MAX_RECORDS     = 16;
	localparam int IMG_OFFSET      = 'h40;
	localparam int RESET_CYCLES    = 5;
	// register phase at most four clocks per record, then three frames
	localparam int WATCHDOG_CLKS   = RESET_CYCLES + 4 * MAX_RECORDS + 3 * FRAME_CLKS;

	logic       clk;
	logic       reg_reset;
	logic [3:0] bus_cycle;
	logic       reg_sel;
	logic       reg_rw;
	logic       reg_uds;
	logic       reg_lds;
	reg_addr_t  reg_addr;
	word_t      reg_din;
	word_t      reg_dout;
	logic       read;
	addr_t      vaddr;
	word_t      data;
	logic       hs;
	logic       vs;
	logic [5:0] video_r;
	logic [5:0] video_g;
	logic [5:0] video_b;
	logic       st_de;
	logic       st_hs;
	logic       st_vs;

	// register records from @00, memory image from @40
	word_t pat [0:255];

	int    errors;
	int    checks;
	int    tests_run;
	int    tests_failed;
	string cur_test;
	addr_t img_base;
	int    exp_ones;

	// per frame counters, cleared on each raw vsync rise
	int    fetch_cnt;
	int    pix_cnt;
	int    hs_cnt;
	int    de_cnt;
	int    hs_act_cnt;
	int    vs_act_cnt;
	int    last_fetch;
	int    last_pix;
	int    last_hs;
	int    last_de;
	int    last_hs_act;
	int    last_vs_act;
	int    frame_cnt;
	logic  fetch_done;
	logic  st_hs_q;
	logic  st_vs_q;

	shifter_top #(
		.H_BORDER_RIGHT(T_H_BORDER_RIGHT), .H_BLANK_RIGHT(T_H_BLANK_RIGHT),
		.H_SYNC(T_H_SYNC), .H_BLANK_LEFT(T_H_BLANK_LEFT), .H_BORDER_LEFT(T_H_BORDER_LEFT),
		.H_END(T_H_END), .V_BORDER_BOT(T_V_BORDER_BOT), .V_BLANK_BOT(T_V_BLANK_BOT),
		.V_SYNC(T_V_SYNC), .V_BLANK_TOP(T_V_BLANK_TOP), .V_BORDER_TOP(T_V_BORDER_TOP),
		.V_END(T_V_END), .H_SYNC_POL(H_POL), .V_SYNC_POL(V_POL)
	) u_dut (
		.clk(clk), .reg_reset(reg_reset), .bus_cycle(bus_cycle), .reg_sel(reg_sel),
		.reg_rw(reg_rw), .reg_uds(reg_uds), .reg_lds(reg_lds), .reg_addr(reg_addr),
		.reg_din(reg_din), .reg_dout(reg_dout), .read(read), .vaddr(vaddr), .data(data),
		.hs(hs), .vs(vs), .video_r(video_r), .video_g(video_g), .video_b(video_b),
		.st_de(st_de), .st_hs(st_hs), .st_vs(st_vs)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	function automatic int count_ones(input word_t w);
		int n;
		n = 0;
		for (int i = 0; i < 16; i++) begin
			n += w[i];
		end
		return n;
	endfunction

	// image words from the base upward, elsewhere a value tied to the address
	function automatic word_t mem_word(input addr_t a);
		addr_t off;
		off = a - img_base;
		if (off < WORDS_PER_FRAME) begin
			return pat[IMG_OFFSET + off];
		end
		return a[15:0] ^ {a[22:16], a[22:14]};
	endfunction

	task automatic check_eq(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			$display("error %s %s: expected %h, actual %h", cur_test, what, expected, actual);
			errors++;
		end
	endtask

	task automatic report_failure(input string msg);
		$display("%s: %s", cur_test, msg);
		errors++;
	endtask

	task automatic finish_test(input string name, input int start_err);
		tests_run++;
		if (errors == start_err) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - start_err);
		end
	endtask

	task automatic reg_write(input reg_addr_t a, input logic [1:0] strobe, input word_t d);
		@(posedge clk);
		#1;
		reg_sel  = 1'b1;
		reg_rw   = 1'b0;
		reg_uds  = strobe[1];
		reg_lds  = strobe[0];
		reg_addr = a;
		reg_din  = d;
		@(posedge clk);
		#1;
		reg_sel = 1'b0;
		reg_rw  = 1'b1;
		reg_uds = 1'b1;
		reg_lds = 1'b1;
	endtask

	// read mux is combinational, sampled half a clock later
	task automatic reg_read(input reg_addr_t a, output word_t d);
		@(posedge clk);
		#1;
		reg_sel  = 1'b1;
		reg_rw   = 1'b1;
		reg_uds  = 1'b0;
		reg_lds  = 1'b0;
		reg_addr = a;
		@(negedge clk);
		d = reg_dout;
		@(posedge clk);
		#1;
		reg_sel = 1'b0;
		reg_uds = 1'b1;
		reg_lds = 1'b1;
	endtask

	// counter registers give a byte address, drop bit 0
	task automatic read_counter(output addr_t a);
		word_t hi;
		word_t mid;
		word_t lo;
		reg_read(REG_ADDR_HI, hi);
		reg_read(REG_ADDR_MID, mid);
		reg_read(REG_ADDR_LO, lo);
		a = {hi[7:0], mid[7:0], lo[7:1]};
	endtask

	task automatic wait_vsync();
		int start;
		start = frame_cnt;
		while (frame_cnt == start) begin
			@(posedge clk);
		end
	endtask

	// ------------------------------------------------------------------------
	// bus slots and memory model, data valid in the fetch slot only
	// ------------------------------------------------------------------------
	always @(posedge clk) begin
		#1;
		bus_cycle = bus_cycle + 4'd1;
		data = (bus_cycle == FETCH_SLOT) ? mem_word(vaddr) : 16'hdead;
	end

	// ------------------------------------------------------------------------
	// frame monitor
	// ------------------------------------------------------------------------
	always @(negedge clk) begin
		logic vs_rise;
		if (reg_reset) begin
			fetch_cnt  = 0;
			pix_cnt    = 0;
			hs_cnt     = 0;
			de_cnt     = 0;
			hs_act_cnt = 0;
			vs_act_cnt = 0;
			frame_cnt  = 0;
			fetch_done = 1'b0;
			st_hs_q    = 1'b0;
			st_vs_q    = 1'b0;
		end else begin
			vs_rise = st_vs && !st_vs_q;
			if (vs_rise) begin
				last_fetch  = fetch_cnt;
				last_pix    = pix_cnt;
				last_hs     = hs_cnt;
				last_de     = de_cnt;
				last_hs_act = hs_act_cnt;
				last_vs_act = vs_act_cnt;
				fetch_cnt   = 0;
				pix_cnt     = 0;
				hs_cnt      = 0;
				de_cnt      = 0;
				hs_act_cnt  = 0;
				vs_act_cnt  = 0;
				fetch_done  = 1'b0;
			end
			if (read) begin
				assert (bus_cycle[3:2] == 2'b00)
					else report_failure("read strobe high outside bus slots 0 to 3");
			end
			// one word per fetch slot, addresses climb from the base
			if (read && (bus_cycle == FETCH_SLOT)) begin
				check_eq("fetch address", img_base + fetch_cnt, vaddr);
				fetch_cnt++;
			end
			if ((fetch_cnt >= WORDS_PER_FRAME) && st_de) begin
				fetch_done = 1'b1;
			end
			if ((hs == H_POL) || (vs == V_POL)) begin
				assert ({video_r, video_g, video_b} == 18'h0)
					else report_failure("video not blanked while sync is active");
			end
			if ((video_r == 6'h3f) && (video_g == 6'h3f) && (video_b == 6'h3f)) begin
				pix_cnt++;
			end
			// st_de is active low
			if (!st_de) begin
				de_cnt++;
			end
			if (hs == H_POL) begin
				hs_act_cnt++;
			end
			if (vs == V_POL) begin
				vs_act_cnt++;
			end
			if (st_hs && !st_hs_q) begin
				hs_cnt++;
			end
			st_hs_q = st_hs;
			st_vs_q = st_vs;
			// bumped last, the test process waits on it
			if (vs_rise) begin
				frame_cnt++;
			end
		end
	end

	// ------------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------------
	task automatic run_registers();
		int    start_err;
		int    n;
		word_t got;
		cur_test  = "register_readback";
		start_err = errors;
		@(negedge clk);
		check_eq("outputs after reset", {1'b0, 1'b1, ~H_POL, ~V_POL, 18'h0},
			{read, st_de, hs, vs, video_r, video_g, video_b});
		assert (!$isunknown(pat[0])) else report_failure("pattern file was not loaded");
		n = 0;
		while ((n < MAX_RECORDS) && !$isunknown(pat[4 * n]) && (pat[4 * n] !== 16'hffff)) begin
			reg_write(reg_addr_t'(pat[4 * n]), pat[4 * n + 1][1:0], pat[4 * n + 2]);
			reg_read(reg_addr_t'(pat[4 * n]), got);
			check_eq($sformatf("register %h", pat[4 * n][5:0]), pat[4 * n + 3], got);
			// image sits at the base the records leave behind
			if (pat[4 * n] == REG_BASE_HI) begin
				img_base[22:15] = pat[4 * n + 3][7:0];
			end
			if (pat[4 * n] == REG_BASE_LO) begin
				img_base[14:7] = pat[4 * n + 3][7:0];
			end
			n++;
		end
		assert (n > 0) else report_failure("no register records found");
		finish_test(cur_test, start_err);
	endtask

	// starts right after a vsync rise, ends at the next one
	task automatic run_frame(input string name, input logic inv);
		int    start_err;
		int    start_frame;
		int    exp_pix;
		addr_t counter;
		cur_test    = name;
		start_err   = errors;
		start_frame = frame_cnt;
		// palette lands well before the first display line
		reg_write(REG_PALETTE0, 2'b00, {15'h0000, inv});
		read_counter(counter);
		check_eq("counter after vsync", img_base, counter);
		while (!fetch_done) begin
			@(posedge clk);
		end
		read_counter(counter);
		check_eq("counter after last fetch", img_base + WORDS_PER_FRAME, counter);
		while (frame_cnt == start_frame) begin
			@(posedge clk);
		end
		exp_pix = inv ? (WORDS_PER_FRAME * PIXELS_PER_WORD - exp_ones) : exp_ones;
		check_eq("words fetched", WORDS_PER_FRAME, last_fetch);
		check_eq("full intensity pixels", exp_pix, last_pix);
		check_eq("hsync pulses per vsync", T_V_END + 1, last_hs);
		check_eq("display enable clocks", DE_CLKS, last_de);
		check_eq("hsync active clocks", HS_CLKS, last_hs_act);
		check_eq("vsync active clocks", VS_CLKS, last_vs_act);
		finish_test(name, start_err);
	endtask

	initial begin
		reg_reset    = 1'b1;
		bus_cycle    = 4'd0;
		reg_sel      = 1'b0;
		reg_rw       = 1'b1;
		reg_uds      = 1'b1;
		reg_lds      = 1'b1;
		reg_addr     = '0;
		reg_din      = '0;
		data         = '0;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		exp_ones     = 0;
		cur_test     = "reset";
		img_base     = BASE_ADDR_RESET;
		$readmemh("testbench/shifter_patterns.txt", pat);
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reg_reset = 1'b0;

		run_registers();
		for (int i = 0; i < WORDS_PER_FRAME; i++) begin
			exp_ones += count_ones(pat[IMG_OFFSET + i]);
		end
		wait_vsync();
		run_frame("frame_plain", 1'b0);
		run_frame("frame_inverted", 1'b1);

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		repeat (WATCHDOG_CLKS) @(posedge clk);
		$display("watchdog expired after %0d clocks, frame tests did not complete",
			WATCHDOG_CLKS);
		$display("Regression failed");
		$finish;
	end

endmodule
